/* aluIssue.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module aluIssue
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic [`RS_COUNT-1:0]   rsReady,
    input  opType                  rsOp   [`RS_COUNT],
    input  logic [`DATA_WIDTH-1:0] rsImm  [`RS_COUNT],
    input  logic [`DATA_WIDTH-1:0] rsSrc1 [`RS_COUNT],
    input  logic [`DATA_WIDTH-1:0] rsSrc2 [`RS_COUNT],
    input  nickType                rsNick [`RS_COUNT],
    output logic [`RS_COUNT-1:0]   rsClear,
    output logic                   cdbValid,
    output nickType                cdbNick,
    output logic [`DATA_WIDTH-1:0] cdbData
);
    int                     sel;
    logic                   found;
    opType                  op;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] result;

    always_comb begin
        sel   = 0;
        found = 1'b0;
        for (int i = 0; i < `RS_COUNT; i++) begin
            if (!found && rsReady[i]) begin
                sel   = i;
                found = 1'b1;
            end
        end
    end

    assign rsClear = (rdy && found) ? `RS_COUNT'(1) << sel : '0;
    assign op      = rsOp[sel];
    assign opA     = rsSrc1[sel];
    assign opB     = (opClass(op) == TWO_SRC) ? rsSrc2[sel] : rsImm[sel];

    always_comb begin
        case (op)
            OP_LUI:          result = rsImm[sel];  // Already shifted by decode
            OP_ADD, OP_ADDI: result = opA + opB;
            OP_SUB:          result = opA - opB;
            OP_XOR, OP_XORI: result = opA ^ opB;
            OP_OR, OP_ORI:   result = opA | opB;
            OP_AND, OP_ANDI: result = opA & opB;
            OP_SLL, OP_SLLI: result = opA << opB[4:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            cdbValid <= 1'b0;
        else
            cdbValid <= rdy && found;
    end

    always_ff @(posedge clk) begin
        cdbNick <= rsNick[sel];
        cdbData <= result;
    end

    assert property (@(posedge clk) disable iff (rst) cdbValid |-> cdbNick != '0);

endmodule

/* dispatch.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module dispatch
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instValid,
    input  opType                  instOp,
    input  regName                 instRd,
    input  logic [`DATA_WIDTH-1:0] instImm,
    input  logic [`DATA_WIDTH-1:0] rs1Data,
    input  logic [`DATA_WIDTH-1:0] rs2Data,
    input  nickType                rs1Nick,
    input  nickType                rs2Nick,
    input  nickType                freeNick,
    input  logic                   robFull,
    input  logic                   lookupDone1,
    input  logic                   lookupDone2,
    input  logic [`DATA_WIDTH-1:0] lookupData1,
    input  logic [`DATA_WIDTH-1:0] lookupData2,
    input  logic                   cdbValid,
    input  nickType                cdbNick,
    input  logic [`DATA_WIDTH-1:0] cdbData,
    input  logic [`RS_COUNT-1:0]   rsBusy,
    output logic [`RS_COUNT-1:0]   rsWrite,
    output opType                  dispOp,
    output logic [`DATA_WIDTH-1:0] dispImm,
    output nickType                dispRs1Nick,
    output logic [`DATA_WIDTH-1:0] dispRs1Data,
    output nickType                dispRs2Nick,
    output logic [`DATA_WIDTH-1:0] dispRs2Data,
    output nickType                dispNick,
    output logic                   renameEn,
    output logic                   allocEn,
    output logic                   dispatchStall
);
    nickType                src1Nick;
    nickType                src2Nick;
    logic [`DATA_WIDTH-1:0] src1Data;
    logic [`DATA_WIDTH-1:0] src2Data;
    logic [`RS_COUNT-1:0]   freeSlot;

    // Register file, then finished ROB slot, then live CDB
    function automatic logic [`NICK_WIDTH+`DATA_WIDTH-1:0] resolve(
        input nickType nick, input logic [`DATA_WIDTH-1:0] regVal,
        input logic done, input logic [`DATA_WIDTH-1:0] robVal,
        input logic bcast, input nickType bcastNick, input logic [`DATA_WIDTH-1:0] bcastVal);
        if (nick == '0)
            return {nick, regVal};
        if (done)
            return {nickType'(0), robVal};
        if (bcast && bcastNick == nick)
            return {nickType'(0), bcastVal};
        return {nick, `DATA_WIDTH'(0)};  // Still waiting
    endfunction

    assign {src1Nick, src1Data} = resolve(rs1Nick, rs1Data, lookupDone1, lookupData1,
                                          cdbValid, cdbNick, cdbData);
    assign {src2Nick, src2Data} = resolve(rs2Nick, rs2Data, lookupDone2, lookupData2,
                                          cdbValid, cdbNick, cdbData);

    always_comb begin
        freeSlot = '0;
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (!rsBusy[i])
                freeSlot = `RS_COUNT'(1) << i;  // Lowest free wins
        end
    end

    assign dispatchStall = robFull || &rsBusy;
    assign allocEn       = instValid && !dispatchStall;
    assign renameEn      = allocEn && instRd != '0;  // x0 stays ready
    assign rsWrite       = allocEn ? freeSlot : '0;
    assign dispOp        = instOp;
    assign dispImm       = instImm;
    assign dispNick      = freeNick;

    always_comb begin
        dispRs1Nick = '0;
        dispRs1Data = '0;
        dispRs2Nick = '0;
        dispRs2Data = '0;
        if (opClass(instOp) != NO_SRC) begin
            dispRs1Nick = src1Nick;
            dispRs1Data = src1Data;
        end
        if (opClass(instOp) == TWO_SRC) begin
            dispRs2Nick = src2Nick;
            dispRs2Data = src2Data;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(instValid && dispatchStall))
        else $error("Instruction sent while dispatch stalled");

endmodule

/* isaPkg.sv */
`include "tomasuloCore_defines.svh"

package isaPkg;

    typedef enum logic [3:0] {
        OP_LUI,
        OP_ADDI, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI,
        OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND, OP_SLL
    } opType;

    typedef enum logic [1:0] {NO_SRC, ONE_SRC, TWO_SRC} srcClass;

    typedef logic [$clog2(`REG_COUNT)-1:0] regName;

    // How many register sources an opcode reads
    function automatic srcClass opClass(input opType op);
        case (op)
            OP_LUI: return NO_SRC;
            OP_ADDI, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI: return ONE_SRC;
            default: return TWO_SRC;
        endcase
    endfunction

endpackage

/* regStatus.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module regStatus
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  regName                 rs1,
    input  regName                 rs2,
    output logic [`DATA_WIDTH-1:0] rs1Data,
    output logic [`DATA_WIDTH-1:0] rs2Data,
    output nickType                rs1Nick,
    output nickType                rs2Nick,
    input  logic                   renameEn,
    input  regName                 renameReg,
    input  nickType                renameNick,
    input  logic                   commitEn,
    input  regName                 commitReg,
    input  nickType                commitNick,
    input  logic [`DATA_WIDTH-1:0] commitData
);
    logic [`DATA_WIDTH-1:0] regValue [`REG_COUNT];
    nickType                regNick  [`REG_COUNT];
    logic                   commitHit1;
    logic                   commitHit2;

    // ROB slot is already freed during the commit cycle, so forward here
    assign commitHit1 = commitEn && commitReg == rs1 && commitNick == regNick[rs1];
    assign commitHit2 = commitEn && commitReg == rs2 && commitNick == regNick[rs2];

    assign rs1Nick = commitHit1 ? '0 : regNick[rs1];
    assign rs2Nick = commitHit2 ? '0 : regNick[rs2];
    assign rs1Data = commitHit1 ? commitData : regValue[rs1];
    assign rs2Data = commitHit2 ? commitData : regValue[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regValue[i] <= '0;
                regNick[i]  <= '0;
            end
        end else begin
            if (commitEn && commitReg != '0) begin
                regValue[commitReg] <= commitData;
                if (regNick[commitReg] == commitNick)
                    regNick[commitReg] <= '0;  // Only if not renamed since
            end
            if (renameEn)
                regNick[renameReg] <= renameNick;  // Wins over same-cycle commit
        end
    end

endmodule

/* renamePkg.sv */
`include "tomasuloCore_defines.svh"

package renamePkg;

    typedef logic [`NICK_WIDTH-1:0] nickType;

    typedef enum logic [1:0] {FREE, WAITING, DONE} robState;

endpackage

/* robQueue.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module robQueue
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   allocEn,
    input  regName                 allocReg,
    output nickType                freeNick,
    output logic                   robFull,
    input  nickType                lookupNick1,
    input  nickType                lookupNick2,
    output logic                   lookupDone1,
    output logic                   lookupDone2,
    output logic [`DATA_WIDTH-1:0] lookupData1,
    output logic [`DATA_WIDTH-1:0] lookupData2,
    input  logic                   cdbValid,
    input  nickType                cdbNick,
    input  logic [`DATA_WIDTH-1:0] cdbData,
    output logic                   commitValid,
    output regName                 commitReg,
    output nickType                commitNick,
    output logic [`DATA_WIDTH-1:0] commitData
);
    robState                         slotState [1:`ROB_DEPTH];
    regName                          slotReg   [1:`ROB_DEPTH];
    logic [`DATA_WIDTH-1:0]          slotData  [1:`ROB_DEPTH];
    nickType                         head;
    nickType                         tail;
    logic [$clog2(`ROB_DEPTH+1)-1:0] count;
    logic                            doCommit;

    function automatic nickType nextNick(input nickType n);
        return (n == `ROB_DEPTH) ? nickType'(1) : nickType'(n + 1'b1);
    endfunction

    assign freeNick = tail;
    assign robFull  = count == `ROB_DEPTH;
    assign doCommit = rdy && slotState[head] == DONE;

    assign lookupDone1 = lookupNick1 != '0 && slotState[lookupNick1] == DONE;
    assign lookupDone2 = lookupNick2 != '0 && slotState[lookupNick2] == DONE;
    assign lookupData1 = slotData[lookupNick1];
    assign lookupData2 = slotData[lookupNick2];

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= nickType'(1);
            tail        <= nickType'(1);
            count       <= '0;
            commitValid <= 1'b0;
            for (int i = 1; i <= `ROB_DEPTH; i++)
                slotState[i] <= FREE;
        end else begin
            commitValid <= doCommit;
            if (cdbValid)
                slotState[cdbNick] <= DONE;
            if (allocEn) begin
                slotState[tail] <= WAITING;
                tail            <= nextNick(tail);
            end
            if (doCommit) begin
                slotState[head] <= FREE;
                head            <= nextNick(head);
            end
            if (allocEn && !doCommit)
                count <= count + 1'b1;
            else if (!allocEn && doCommit)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn)
            slotReg[tail] <= allocReg;
        if (cdbValid)
            slotData[cdbNick] <= cdbData;
        commitReg  <= slotReg[head];
        commitNick <= head;
        commitData <= slotData[head];
    end

    // Count would pass ROB_DEPTH
    assert property (@(posedge clk) disable iff (rst) robFull |-> !allocEn)
        else $error("Allocation into a full ROB");
    assert property (@(posedge clk) disable iff (rst) cdbValid |-> slotState[cdbNick] != FREE)
        else $error("CDB result for a free ROB slot");

endmodule

/* rsEntry.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module rsEntry
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   write,
    input  logic                   clear,
    input  opType                  dispOp,
    input  logic [`DATA_WIDTH-1:0] dispImm,
    input  nickType                dispRs1Nick,
    input  logic [`DATA_WIDTH-1:0] dispRs1Data,
    input  nickType                dispRs2Nick,
    input  logic [`DATA_WIDTH-1:0] dispRs2Data,
    input  nickType                dispNick,
    input  logic                   cdbValid,
    input  nickType                cdbNick,
    input  logic [`DATA_WIDTH-1:0] cdbData,
    output logic                   busy,
    output logic                   ready,
    output opType                  op,
    output logic [`DATA_WIDTH-1:0] imm,
    output logic [`DATA_WIDTH-1:0] src1,
    output logic [`DATA_WIDTH-1:0] src2,
    output nickType                nick
);
    nickType src1Nick;
    nickType src2Nick;
    logic    hit1;
    logic    hit2;

    // cdbNick is never 0, so a present operand cannot match
    assign hit1  = cdbValid && src1Nick == cdbNick;
    assign hit2  = cdbValid && src2Nick == cdbNick;
    assign ready = busy && src1Nick == '0 && src2Nick == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            src1Nick <= '0;
            src2Nick <= '0;
        end else if (write) begin
            busy     <= 1'b1;
            src1Nick <= dispRs1Nick;
            src2Nick <= dispRs2Nick;
        end else begin
            if (clear)
                busy <= 1'b0;
            if (hit1)
                src1Nick <= '0;
            if (hit2)
                src2Nick <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            op   <= dispOp;
            imm  <= dispImm;
            nick <= dispNick;
            src1 <= dispRs1Data;
            src2 <= dispRs2Data;
        end else begin
            if (hit1)
                src1 <= cdbData;
            if (hit2)
                src2 <= cdbData;
        end
    end

    assert property (@(posedge clk) disable iff (rst) write |-> !busy);
    assert property (@(posedge clk) disable iff (rst) clear |-> ready)
        else $error("Issue cleared an entry that was not ready");

endmodule

/* tomasuloCore.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module tomasuloCore
    import isaPkg::*;
    import renamePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   instValid,
    input  opType                  instOp,
    input  regName                 instRd,
    input  regName                 instRs1,
    input  regName                 instRs2,
    input  logic [`DATA_WIDTH-1:0] instImm,
    output logic                   dispatchStall,
    output logic                   commitValid,
    output regName                 commitReg,
    output logic [`DATA_WIDTH-1:0] commitData
);
    logic [`DATA_WIDTH-1:0] rs1Data;
    logic [`DATA_WIDTH-1:0] rs2Data;
    nickType                rs1Nick;
    nickType                rs2Nick;
    nickType                freeNick;
    nickType                commitNick;
    logic                   robFull;
    logic                   renameEn;
    logic                   allocEn;
    logic                   lookupDone1;
    logic                   lookupDone2;
    logic [`DATA_WIDTH-1:0] lookupData1;
    logic [`DATA_WIDTH-1:0] lookupData2;
    logic                   cdbValid;
    nickType                cdbNick;
    logic [`DATA_WIDTH-1:0] cdbData;

    logic [`RS_COUNT-1:0]   rsBusy;
    logic [`RS_COUNT-1:0]   rsReady;
    logic [`RS_COUNT-1:0]   rsWrite;
    logic [`RS_COUNT-1:0]   rsClear;
    opType                  dispOp;
    logic [`DATA_WIDTH-1:0] dispImm;
    nickType                dispRs1Nick;
    logic [`DATA_WIDTH-1:0] dispRs1Data;
    nickType                dispRs2Nick;
    logic [`DATA_WIDTH-1:0] dispRs2Data;
    nickType                dispNick;
    opType                  rsOp   [`RS_COUNT];
    logic [`DATA_WIDTH-1:0] rsImm  [`RS_COUNT];
    logic [`DATA_WIDTH-1:0] rsSrc1 [`RS_COUNT];
    logic [`DATA_WIDTH-1:0] rsSrc2 [`RS_COUNT];
    nickType                rsNick [`RS_COUNT];

    regStatus uRegStatus (
        .clk, .rst, .rs1(instRs1), .rs2(instRs2),
        .rs1Data, .rs2Data, .rs1Nick, .rs2Nick,
        .renameEn, .renameReg(instRd), .renameNick(dispNick),
        .commitEn(commitValid), .commitReg, .commitNick, .commitData
    );

    robQueue uRob (
        .clk, .rst, .rdy, .allocEn, .allocReg(instRd), .freeNick, .robFull,
        .lookupNick1(rs1Nick), .lookupNick2(rs2Nick),  // Nicks straight from regStatus
        .lookupDone1, .lookupDone2, .lookupData1, .lookupData2,
        .cdbValid, .cdbNick, .cdbData,
        .commitValid, .commitReg, .commitNick, .commitData
    );

    dispatch uDispatch (
        .clk, .rst, .instValid, .instOp, .instRd, .instImm,
        .rs1Data, .rs2Data, .rs1Nick, .rs2Nick, .freeNick, .robFull,
        .lookupDone1, .lookupDone2, .lookupData1, .lookupData2,
        .cdbValid, .cdbNick, .cdbData, .rsBusy, .rsWrite,
        .dispOp, .dispImm, .dispRs1Nick, .dispRs1Data, .dispRs2Nick, .dispRs2Data,
        .dispNick, .renameEn, .allocEn, .dispatchStall
    );

    for (genvar i = 0; i < `RS_COUNT; i++) begin : gRs
        rsEntry uEntry (
            .clk, .rst, .write(rsWrite[i]), .clear(rsClear[i]),
            .dispOp, .dispImm, .dispRs1Nick, .dispRs1Data, .dispRs2Nick, .dispRs2Data,
            .dispNick, .cdbValid, .cdbNick, .cdbData,
            .busy(rsBusy[i]), .ready(rsReady[i]), .op(rsOp[i]), .imm(rsImm[i]),
            .src1(rsSrc1[i]), .src2(rsSrc2[i]), .nick(rsNick[i])
        );
    end

    aluIssue uIssue (
        .clk, .rst, .rdy, .rsReady, .rsOp, .rsImm, .rsSrc1, .rsSrc2, .rsNick,
        .rsClear, .cdbValid, .cdbNick, .cdbData
    );

endmodule

/* tomasuloCoreTb.sv */
`timescale 1ns/1ns
`include "tomasuloCore_defines.svh"

module tomasuloCoreTb
    import isaPkg::*;
;
    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   instValid;
    opType                  instOp;
    regName                 instRd;
    regName                 instRs1;
    regName                 instRs2;
    logic [`DATA_WIDTH-1:0] instImm;
    logic                   dispatchStall;
    logic                   commitValid;
    regName                 commitReg;
    logic [`DATA_WIDTH-1:0] commitData;

    integer                 seed = 18764;
    logic [`DATA_WIDTH-1:0] modelRegs [`REG_COUNT];
    regName                 expReg [$];  // Expected commits in program order
    logic [`DATA_WIDTH-1:0] expData [$];
    int                     commitIdx = 0;
    int                     sentCount = 0;
    int                     cycleCount = 0;
    int                     lowSends = 0;  // Dispatches since rdy went low
    bit                     sent;

    tomasuloCore dut (.*);

    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic [`DATA_WIDTH-1:0] expectedResult(input opType op,
        input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b,
        input logic [`DATA_WIDTH-1:0] imm);
        case (op)
            OP_LUI:  return imm;
            OP_ADDI: return a + imm;
            OP_XORI: return a ^ imm;
            OP_ORI:  return a | imm;
            OP_ANDI: return a & imm;
            OP_SLLI: return a << imm[4:0];
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            default: return a << b[4:0];  // SLL
        endcase
    endfunction

    // One attempt per cycle, instruction held back while stalled
    task automatic trySend(input opType op, input regName rd, input regName rs1,
        input regName rs2, input logic [`DATA_WIDTH-1:0] imm, output bit ok);
        logic [`DATA_WIDTH-1:0] result;
        @(posedge clk);
        #1;
        if (dispatchStall) begin
            instValid = 1'b0;
            ok = 1'b0;
        end else begin
            instValid = 1'b1;
            instOp = op;
            instRd = rd;
            instRs1 = rs1;
            instRs2 = rs2;
            instImm = imm;
            result = expectedResult(op, modelRegs[rs1], modelRegs[rs2], imm);
            expReg.push_back(rd);
            expData.push_back(result);
            if (rd != 0)
                modelRegs[rd] = result;
            sentCount++;
            ok = 1'b1;
        end
    endtask

    task automatic sendInst(input opType op, input regName rd, input regName rs1,
        input regName rs2, input logic [`DATA_WIDTH-1:0] imm);
        bit ok;
        do begin
            trySend(op, rd, rs1, rs2, imm, ok);
            if (!ok)
                rdy = 1'b1;  // Release a random pause
        end while (!ok);
    endtask

    task automatic randomInst();
        opType                  op;
        logic [`DATA_WIDTH-1:0] imm;
        op  = opType'($unsigned($random(seed)) % 12);
        imm = $random(seed);
        if (op == OP_LUI)
            imm[11:0] = '0;
        else if (op == OP_SLLI)
            imm = imm & 31;
        else if (op != OP_ADD && op != OP_SUB && op != OP_XOR && op != OP_OR
                 && op != OP_AND && op != OP_SLL)
            imm = {{20{imm[11]}}, imm[11:0]};
        sendInst(op, regName'($random(seed) & 7), regName'($random(seed) & 7),
                 regName'($random(seed) & 7), imm);
    endtask

    task automatic waitDrain();
        @(posedge clk);
        #1;
        instValid = 1'b0;
        rdy = 1'b1;
        wait (commitIdx == expReg.size());
        repeat (5) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!rst && commitValid)
            commitIdx <= commitIdx + 1;
        if (rdy)
            lowSends <= 0;
        else if (instValid && !dispatchStall)
            lowSends <= lowSends + 1;
        if (cycleCount > 40 * sentCount + 200)
            failRun($sformatf("Timeout after %0d cycles with %0d of %0d commits seen",
                              cycleCount, commitIdx, expReg.size()));
    end

    assert property (@(posedge clk) rst && cycleCount > 0 |-> !commitValid && !dispatchStall)
        else failRun($sformatf("ERROR at %0t: commit or stall active during reset", $time));
    assert property (@(posedge clk) cycleCount > 1 && !rst && $past(rst)
                     |-> !commitValid && !dispatchStall)
        else failRun($sformatf("ERROR at %0t: commit or stall active after reset", $time));
    assert property (@(posedge clk) disable iff (rst)
        commitValid |-> commitIdx < expReg.size() && commitReg == expReg[commitIdx]
                        && commitData == expData[commitIdx])
        else failRun($sformatf("ERROR at %0t: commit %0d gave x%0d = %h, expected x%0d = %h",
                     $time, $sampled(commitIdx), $sampled(commitReg), $sampled(commitData),
                     expReg[$sampled(commitIdx)], expData[$sampled(commitIdx)]));
    assert property (@(posedge clk) disable iff (rst) !$past(rdy) |-> !commitValid)
        else failRun($sformatf("ERROR at %0t: commit while rdy was low", $time));
    assert property (@(posedge clk) disable iff (rst) !rdy && lowSends >= `RS_COUNT
                     |-> dispatchStall)
        else failRun($sformatf("ERROR at %0t: no stall after %0d dispatches", $time, lowSends));

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        instValid = 1'b0;
        instOp = OP_LUI;
        instRd = '0;
        instRs1 = '0;
        instRs2 = '0;
        instImm = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            modelRegs[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Independent ops
        sendInst(OP_LUI, 1, 0, 0, 32'h12345000);
        sendInst(OP_ADDI, 2, 0, 0, 32'hffff_fff9);
        sendInst(OP_ORI, 3, 0, 0, 32'h0000_05a5);
        sendInst(OP_XORI, 4, 0, 0, 32'h0000_0123);
        waitDrain();

        // Back-to-back dependent chain
        sendInst(OP_ADDI, 3, 1, 0, 1);
        sendInst(OP_ADD, 4, 3, 3, 0);
        sendInst(OP_SUB, 5, 4, 1, 0);
        sendInst(OP_SLLI, 6, 5, 0, 3);
        sendInst(OP_SLL, 7, 6, 2, 0);
        sendInst(OP_AND, 3, 7, 5, 0);
        sendInst(OP_XOR, 4, 3, 4, 0);
        waitDrain();

        // x0 commits its value but reads stay zero
        sendInst(OP_ADDI, 0, 1, 0, 77);
        sendInst(OP_ADD, 5, 0, 1, 0);
        sendInst(OP_ORI, 6, 0, 0, 32'h0000_0042);
        waitDrain();

        // Back-pressure with rdy held low
        @(posedge clk);
        #1;
        rdy = 1'b0;
        for (int i = 0; i < `RS_COUNT + 3; i++)
            trySend(OP_ADDI, regName'(i % 7 + 1), regName'(i % 7), 0, i + 1, sent);
        repeat (3) @(posedge clk);
        waitDrain();

        // Random program with random rdy pauses
        repeat (200) begin
            randomInst();
            rdy = ($random(seed) & 3) != 0;
        end
        waitDrain();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tomasuloCore_defines.svh */
`ifndef TOMASULO_CORE_DEFINES_SVH
`define TOMASULO_CORE_DEFINES_SVH

`define DATA_WIDTH 32
`define NICK_WIDTH 3  // Nick 0 means value present
`define ROB_DEPTH  7  // Slots named by nicks 1..7
`define RS_COUNT   4
`define REG_COUNT  32

`endif

/* verilog.f */
+incdir+.
isaPkg.sv
renamePkg.sv
regStatus.sv
robQueue.sv
dispatch.sv
rsEntry.sv
aluIssue.sv
tomasuloCore.sv
tomasuloCoreTb.sv
